// File: design/fetch_pkg.sv
package fetch_pkg;

    // byte counts of one instruction and one fetch
    localparam int INSTR_BYTES = 4;
    localparam int FETCH_BYTES = 8;

    // address or one instruction
    typedef logic [INSTR_BYTES*8-1:0] word_t;

    // one bus response, two instructions
    // lower half is the instruction at the fetch address
    typedef logic [FETCH_BYTES*8-1:0] fetch_word_t;

    // one fetch in flight between pc and decode
    typedef struct packed {
        // entry holds a real fetch
        logic  valid;
        // address of slot 0
        word_t pc;
        // misaligned fetch, no bus request was made
        logic  fetch_exc;
    } fetch_entry_t;

endpackage

// File: design/fetch_ctrl_if.sv
interface fetch_ctrl_if import fetch_pkg::*; ();

    // pc is aligned, request on the instruction bus
    logic  ireq_valid;

    // hold pc and keep the request up
    logic  stall_f;
    // hold f1 entry and output register
    logic  stall_f2;

    // kill whatever would enter f1 this edge
    logic  flush_f1;
    // kill the output register toward decode
    logic  flush_out;

    // new pc this edge
    logic  redirect_valid;
    word_t redirect_target;

    // stall, flush and redirect source
    modport ctrl (
        input  ireq_valid,
        output stall_f, stall_f2, flush_f1, flush_out, redirect_valid, redirect_target
    );

    // pc and f1 entry side
    modport addr_side (
        output ireq_valid,
        input  stall_f, stall_f2, flush_f1, redirect_valid, redirect_target
    );

    // response buffer and output register side
    modport pair_side (
        input  stall_f2, flush_out
    );

endinterface

// File: design/fetch_control.sv
module fetch_control import fetch_pkg::*; #(
    parameter word_t EXC_ENTRANCE = 32'hbfc0_0380
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  exc_valid,
    input  logic  eret_valid,
    input  logic  branch_taken,
    input  word_t epc,
    input  word_t branch_target,
    input  logic  iresp_addr_ok,
    input  logic  stall_d,
    fetch_ctrl_if.ctrl ctl
);

    logic  fetch_wait;
    logic  stall_f;
    logic  event_valid;
    word_t event_target;

    // redirect seen while fetch was stalled
    logic  pending_valid;
    word_t pending_target;

    // request up but memory did not take the address
    assign fetch_wait = ctl.ireq_valid & ~iresp_addr_ok;

    // pc waits on the bus or on a full decode stage
    assign stall_f = fetch_wait | stall_d;

    // any redirect source this cycle
    assign event_valid = exc_valid | eret_valid | branch_taken;

    // fixed priority
    // exception entrance, then eret, then resolved branch
    always_comb begin
        if (exc_valid) begin
            event_target = EXC_ENTRANCE;
        end else if (eret_valid) begin
            event_target = epc;
        end else begin
            event_target = branch_target;
        end
    end

    // pending flag
    // a newer event overwrites, an unstalled edge consumes it
    always_ff @(posedge clk) begin
        if (reset) begin
            pending_valid <= 1'b0;
        end else if (stall_f && event_valid) begin
            pending_valid <= 1'b1;
        end else if (!stall_f) begin
            pending_valid <= 1'b0;
        end
    end

    // pending target, only meaningful with the flag set
    always_ff @(posedge clk) begin
        if (stall_f && event_valid) begin
            pending_target <= event_target;
        end
    end

    assign ctl.stall_f  = stall_f;
    assign ctl.stall_f2 = stall_d;

    // pc moves only on an unstalled edge
    // a fresh event wins over an older pending one
    assign ctl.redirect_valid  = ~stall_f & (event_valid | pending_valid);
    assign ctl.redirect_target = event_valid ? event_target : pending_target;

    // f1 is wrong path on the event itself
    // and again when a held target finally lands
    assign ctl.flush_f1  = event_valid | (pending_valid & ~stall_f);
    assign ctl.flush_out = event_valid;

endmodule

// File: design/fetch_addr_stage.sv
module fetch_addr_stage import fetch_pkg::*; #(
    parameter word_t RESET_VECTOR = 32'hbfc0_0000
) (
    input  logic         clk,
    input  logic         reset,
    fetch_ctrl_if.addr_side ctl,
    output word_t        ireq_addr,
    output fetch_entry_t f1_entry
);

    // low address bits that must be zero
    localparam int ALIGN_BITS = $clog2(INSTR_BYTES);

    word_t pc;
    logic  misaligned;

    // f1 register, valid bit apart from payload
    logic  f1_valid;
    word_t f1_pc;
    logic  f1_exc;

    assign misaligned = |pc[ALIGN_BITS-1:0];

    // misaligned pc makes no bus request
    assign ctl.ireq_valid = ~misaligned;
    assign ireq_addr      = pc;

    // program counter
    // sequential step is one full fetch, two instructions
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_VECTOR;
        end else if (!ctl.stall_f) begin
            if (ctl.redirect_valid) begin
                pc <= ctl.redirect_target;
            end else begin
                pc <= pc + word_t'(FETCH_BYTES);
            end
        end
    end

    // f1 valid
    // flush kills even a held entry, it is wrong path
    // a bus wait with decode free inserts a bubble
    always_ff @(posedge clk) begin
        if (reset) begin
            f1_valid <= 1'b0;
        end else if (ctl.flush_f1) begin
            f1_valid <= 1'b0;
        end else if (!ctl.stall_f2) begin
            f1_valid <= ~ctl.stall_f;
        end
    end

    // f1 payload follows the valid bit's load enable
    always_ff @(posedge clk) begin
        if (!ctl.stall_f2) begin
            f1_pc  <= pc;
            f1_exc <= misaligned;
        end
    end

    assign f1_entry.valid     = f1_valid;
    assign f1_entry.pc        = f1_pc;
    assign f1_entry.fetch_exc = f1_exc;

endmodule

// File: design/fetch_pair_stage.sv
module fetch_pair_stage import fetch_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    fetch_ctrl_if.pair_side ctl,
    input  fetch_entry_t f1_entry,
    input  fetch_word_t  iresp_data,
    output logic         out_valid,
    output word_t        out_pc,
    output word_t        out_instr0,
    output word_t        out_instr1,
    output logic         out_fetch_exc
);

    // instructions per fetch word
    localparam int SLOTS = FETCH_BYTES / INSTR_BYTES;
    localparam int WORD_W = $bits(word_t);

    // response hold buffer
    logic        buf_saved;
    fetch_word_t buf_data;

    // word for the f1 entry, live or buffered
    fetch_word_t fetch_word;
    word_t [SLOTS-1:0] slot;

    // memory drives data for one cycle only
    // so the first stalled cycle grabs it
    always_ff @(posedge clk) begin
        if (reset) begin
            buf_saved <= 1'b0;
        end else if (ctl.stall_f2 && !buf_saved) begin
            buf_saved <= 1'b1;
        end else if (!ctl.stall_f2) begin
            buf_saved <= 1'b0;
        end
    end

    // later stalled cycles see a repeat request, keep the first data
    always_ff @(posedge clk) begin
        if (ctl.stall_f2 && !buf_saved) begin
            buf_data <= iresp_data;
        end
    end

    assign fetch_word = buf_saved ? buf_data : iresp_data;

    // split into slots, slot 0 at the fetch address
    // exception entry carries no instructions
    always_comb begin
        for (int i = 0; i < SLOTS; i++) begin
            if (f1_entry.fetch_exc) begin
                slot[i] = '0;
            end else begin
                slot[i] = fetch_word[i*WORD_W +: WORD_W];
            end
        end
    end

    // output valid
    // squash beats the decode stall
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (ctl.flush_out) begin
            out_valid <= 1'b0;
        end else if (!ctl.stall_f2) begin
            out_valid <= f1_entry.valid;
        end
    end

    // payload toward decode, held while decode is full
    always_ff @(posedge clk) begin
        if (!ctl.stall_f2) begin
            out_pc        <= f1_entry.pc;
            out_instr0    <= slot[0];
            out_instr1    <= slot[1];
            out_fetch_exc <= f1_entry.fetch_exc;
        end
    end

endmodule

// File: design/fetch_unit.sv
module fetch_unit import fetch_pkg::*; #(
    parameter word_t RESET_VECTOR = 32'hbfc0_0000,
    parameter word_t EXC_ENTRANCE = 32'hbfc0_0380
) (
    input  logic        clk,
    input  logic        reset,

    // instruction bus
    output logic        ireq_valid,
    output word_t       ireq_addr,
    input  logic        iresp_addr_ok,
    input  fetch_word_t iresp_data,

    // decode back pressure
    input  logic        stall_d,

    // redirect sources
    input  logic        exc_valid,
    input  logic        eret_valid,
    input  word_t       epc,
    input  logic        branch_taken,
    input  word_t       branch_target,

    // fetch pair toward decode
    output logic        out_valid,
    output word_t       out_pc,
    output word_t       out_instr0,
    output word_t       out_instr1,
    output logic        out_fetch_exc
);

    fetch_entry_t f1_entry;

    // stall, flush and redirect bundle
    fetch_ctrl_if ctl_if ();

    assign ireq_valid = ctl_if.ireq_valid;

    fetch_control #(
        .EXC_ENTRANCE (EXC_ENTRANCE)
    ) u_fetch_control (
        .clk           (clk),
        .reset         (reset),
        .exc_valid     (exc_valid),
        .eret_valid    (eret_valid),
        .branch_taken  (branch_taken),
        .epc           (epc),
        .branch_target (branch_target),
        .iresp_addr_ok (iresp_addr_ok),
        .stall_d       (stall_d),
        .ctl           (ctl_if.ctrl)
    );

    // pc and f1 entry
    fetch_addr_stage #(
        .RESET_VECTOR (RESET_VECTOR)
    ) u_fetch_addr_stage (
        .clk       (clk),
        .reset     (reset),
        .ctl       (ctl_if.addr_side),
        .ireq_addr (ireq_addr),
        .f1_entry  (f1_entry)
    );

    // response buffer, slot split and decode register
    fetch_pair_stage u_fetch_pair_stage (
        .clk           (clk),
        .reset         (reset),
        .ctl           (ctl_if.pair_side),
        .f1_entry      (f1_entry),
        .iresp_data    (iresp_data),
        .out_valid     (out_valid),
        .out_pc        (out_pc),
        .out_instr0    (out_instr0),
        .out_instr1    (out_instr1),
        .out_fetch_exc (out_fetch_exc)
    );

endmodule

// File: tb/fetch_mem_model.sv
module fetch_mem_model import fetch_pkg::*; #(
    parameter int SEED = 32'h6b65_781e
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        ireq_valid,
    input  word_t       ireq_addr,
    output logic        iresp_addr_ok,
    output fetch_word_t iresp_data
);

    timeunit 1ns;
    timeprecision 1ps;

    integer seed;

    initial begin
        seed = SEED;
        iresp_addr_ok = 1'b0;
        iresp_data = 'x;
    end

    // response for an accepted address during the next cycle only
    // upper half is the following instruction address
    // x elsewhere so a late or early read shows up
    always @(posedge clk) begin
        if (!reset && ireq_valid && iresp_addr_ok) begin
            iresp_data <= {ireq_addr + word_t'(INSTR_BYTES), ireq_addr};
        end else begin
            iresp_data <= 'x;
        end
    end

    // address accept, roughly 70 percent of cycles
    always @(posedge clk) begin
        #1;
        iresp_addr_ok = ({$random(seed)} % 10) < 7;
    end

endmodule

// File: tb/tb_fetch_unit.sv
module tb_fetch_unit import fetch_pkg::*;;

    timeunit 1ns;
    timeprecision 1ps;

    localparam word_t RESET_VECTOR = 32'hbfc0_0000;
    localparam word_t EXC_ENTRANCE = 32'hbfc0_0380;
    localparam int CLK_PERIOD = 20;
    localparam int DRIVE_DELAY = 2;
    // longest wait for a redirect target to reach decode
    localparam int LAND_LIMIT = 40;
    // cycles per test, in order
    localparam int LEN_RESET = 10;
    localparam int LEN_SEQ = 40;
    localparam int LEN_STALL = 200;
    localparam int LEN_BRANCH = 8 * (50 + LAND_LIMIT + 12);
    localparam int LEN_PRIO = 2 * (1 + LAND_LIMIT + 15);
    localparam int LEN_MISALIGN = 2 * (1 + LAND_LIMIT + 15);
    localparam int TEST_CYCLES = LEN_RESET + LEN_SEQ + LEN_STALL + LEN_BRANCH + LEN_PRIO
                                 + LEN_MISALIGN;

    logic        clk;
    logic        reset;
    logic        ireq_valid;
    word_t       ireq_addr;
    logic        iresp_addr_ok;
    fetch_word_t iresp_data;
    logic        stall_d;
    logic        exc_valid;
    logic        eret_valid;
    word_t       epc;
    logic        branch_taken;
    word_t       branch_target;
    logic        out_valid;
    word_t       out_pc;
    word_t       out_instr0;
    word_t       out_instr1;
    logic        out_fetch_exc;

    integer seed;
    int     fail_count;
    int     fails_at_start;
    int     tests_ok;
    int     tests_bad;
    int     n;
    logic   ev;
    word_t  ev_target;
    // next pc that decode must see
    word_t  exp_pc;
    // outputs taken by decode so far
    int     outs_seen;
    int     outs_at_start;
    // redirect targets that reached decode
    int     landings;
    logic   land_due;

    fetch_unit #(
        .RESET_VECTOR (RESET_VECTOR),
        .EXC_ENTRANCE (EXC_ENTRANCE)
    ) u_fetch_unit (
        .clk           (clk),
        .reset         (reset),
        .ireq_valid    (ireq_valid),
        .ireq_addr     (ireq_addr),
        .iresp_addr_ok (iresp_addr_ok),
        .iresp_data    (iresp_data),
        .stall_d       (stall_d),
        .exc_valid     (exc_valid),
        .eret_valid    (eret_valid),
        .epc           (epc),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .out_valid     (out_valid),
        .out_pc        (out_pc),
        .out_instr0    (out_instr0),
        .out_instr1    (out_instr1),
        .out_fetch_exc (out_fetch_exc)
    );

    fetch_mem_model #(
        .SEED (32'h6b65_781e)
    ) u_mem (
        .clk           (clk),
        .reset         (reset),
        .ireq_valid    (ireq_valid),
        .ireq_addr     (ireq_addr),
        .iresp_addr_ok (iresp_addr_ok),
        .iresp_data    (iresp_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // any redirect this cycle, target by priority
    assign ev = exc_valid | eret_valid | branch_taken;
    assign ev_target = exc_valid ? EXC_ENTRANCE : (eret_valid ? epc : branch_target);

    // reference
    // redirect restarts the stream, a consumed output steps it by one fetch
    always @(posedge clk) begin
        if (reset) begin
            exp_pc <= RESET_VECTOR;
        end else if (ev) begin
            exp_pc <= ev_target;
        end else if (out_valid && !stall_d) begin
            exp_pc <= exp_pc + word_t'(FETCH_BYTES);
        end
    end

    // progress toward decode
    // first output taken after a redirect is its landing
    always @(posedge clk) begin
        if (reset) begin
            outs_seen <= 0;
            landings <= 0;
            land_due <= 1'b0;
        end else begin
            if (out_valid && !stall_d) begin
                outs_seen <= outs_seen + 1;
            end
            if (ev) begin
                land_due <= 1'b1;
            end else if (out_valid && !stall_d) begin
                land_due <= 1'b0;
                if (land_due) begin
                    landings <= landings + 1;
                end
            end
        end
    end

    a_reset_state: assert property (@(posedge clk) $fell(reset) |->
        !out_valid && ireq_valid && ireq_addr == RESET_VECTOR)
    else begin
        $display("error ireq_addr: got %h expected %h, out_valid %h",
                 $sampled(ireq_addr), RESET_VECTOR, $sampled(out_valid));
        fail_count++;
    end

    a_pc_order: assert property (@(posedge clk) disable iff (reset)
        out_valid && !stall_d |-> out_pc == exp_pc)
    else begin
        $display("error out_pc: got %h expected %h", $sampled(out_pc), $sampled(exp_pc));
        fail_count++;
    end

    a_slots: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_fetch_exc |->
        out_instr0 == out_pc && out_instr1 == out_pc + word_t'(INSTR_BYTES))
    else begin
        $display("error out_instr0/out_instr1: got %h %h for out_pc %h",
                 $sampled(out_instr0), $sampled(out_instr1), $sampled(out_pc));
        fail_count++;
    end

    a_exc_entry: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> out_fetch_exc == (out_pc[1:0] != 2'b00) &&
        (!out_fetch_exc || (out_instr0 == '0 && out_instr1 == '0)))
    else begin
        $display("error out_fetch_exc: got %h for out_pc %h, instrs %h %h",
                 $sampled(out_fetch_exc), $sampled(out_pc),
                 $sampled(out_instr0), $sampled(out_instr1));
        fail_count++;
    end

    a_req_align: assert property (@(posedge clk) disable iff (reset)
        ireq_valid == (ireq_addr[1:0] == 2'b00))
    else begin
        $display("error ireq_valid: got %h for ireq_addr %h",
                 $sampled(ireq_valid), $sampled(ireq_addr));
        fail_count++;
    end

    // decode full, nothing moves unless a flush kills the entry
    a_hold_valid: assert property (@(posedge clk) disable iff (reset)
        stall_d && !ev |=> $stable(out_valid))
    else begin
        $display("error out_valid: changed to %h while decode was stalled",
                 $sampled(out_valid));
        fail_count++;
    end

    a_hold_data: assert property (@(posedge clk) disable iff (reset)
        stall_d && out_valid |=> $stable(out_pc) && $stable(out_instr0) &&
        $stable(out_instr1) && $stable(out_fetch_exc))
    else begin
        $display("error out_pc: changed to %h while decode was stalled", $sampled(out_pc));
        fail_count++;
    end

    // cycles with random decode stalls, percent given
    task automatic run_cycles(input int cycles, input int stall_pct);
        repeat (cycles) begin
            @(posedge clk);
            #DRIVE_DELAY;
            exc_valid = 1'b0;
            eret_valid = 1'b0;
            branch_taken = 1'b0;
            stall_d = ({$random(seed)} % 100) < stall_pct;
        end
    endtask

    // one cycle redirect pulse
    task automatic redirect(input logic exc, input logic eret, input logic br,
                            input word_t target);
        @(posedge clk);
        #DRIVE_DELAY;
        exc_valid = exc;
        eret_valid = eret;
        branch_taken = br;
        epc = target;
        branch_target = br ? target : target + 32'h40;
        stall_d = 1'b0;
    endtask

    // wait for a cycle where memory refuses the address
    task automatic branch_in_wait(input word_t target);
        logic found;
        found = 1'b0;
        for (int i = 0; i < 50 && !found; i++) begin
            if (ireq_valid && !iresp_addr_ok) begin
                branch_taken = 1'b1;
                branch_target = target;
                found = 1'b1;
            end else begin
                @(posedge clk);
                #DRIVE_DELAY;
                branch_taken = 1'b0;
            end
        end
        if (!found) begin
            $display("no fetch wait came up to place the branch in");
            fail_count++;
        end
    endtask

    // random stalls go on until the redirect target reaches decode
    task automatic wait_landing(input int stall_pct);
        int want;
        want = landings + 1;
        for (int i = 0; i < LAND_LIMIT; i++) begin
            run_cycles(1, stall_pct);
            if (landings >= want) begin
                break;
            end
        end
        if (landings < want) begin
            $display("redirect target did not reach decode within %0d cycles", LAND_LIMIT);
            fail_count++;
        end
    endtask

    task automatic end_test(input string name);
        if (outs_seen == outs_at_start) begin
            $display("no valid output reached decode during test %s", name);
            fail_count++;
        end
        outs_at_start = outs_seen;
        if (fail_count == fails_at_start) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            tests_bad++;
            $display("test %s: %0d failures", name, fail_count - fails_at_start);
        end
        fails_at_start = fail_count;
    endtask

    // watchdog
    initial begin
        #(TEST_CYCLES * 40 * CLK_PERIOD);
        $display("timeout: tests did not finish in time");
        $display("Verification failed");
        $finish;
    end

    initial begin
        seed = 32'h6b65_781e;
        fail_count = 0;
        fails_at_start = 0;
        outs_at_start = 0;
        tests_ok = 0;
        tests_bad = 0;
        reset = 1'b1;
        stall_d = 1'b0;
        exc_valid = 1'b0;
        eret_valid = 1'b0;
        branch_taken = 1'b0;
        epc = '0;
        branch_target = '0;
        repeat (3) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;

        run_cycles(LEN_RESET, 0);
        end_test("reset");
        run_cycles(LEN_SEQ, 0);
        end_test("sequential");
        run_cycles(LEN_STALL, 30);
        end_test("random_stall");

        for (n = 0; n < 8; n++) begin
            if (n % 2 == 0) begin
                branch_in_wait(32'h8000_1000 + 32'(n) * 32'h100 + 32'(n % 4) * 4);
            end else begin
                redirect(1'b0, 1'b0, 1'b1, 32'h8000_2004 + 32'(n) * 32'h80);
            end
            wait_landing(25);
            run_cycles(12, 25);
        end
        end_test("branch");

        // exception wins over a branch in the same cycle
        redirect(1'b1, 1'b0, 1'b1, 32'h8000_3000);
        wait_landing(20);
        run_cycles(15, 20);
        redirect(1'b0, 1'b1, 1'b0, 32'h8000_4008);
        wait_landing(20);
        run_cycles(15, 20);
        end_test("priority");

        redirect(1'b0, 1'b0, 1'b1, 32'h8000_5102);
        wait_landing(20);
        run_cycles(15, 20);
        redirect(1'b0, 1'b0, 1'b1, 32'h8000_6000);
        wait_landing(20);
        run_cycles(15, 20);
        end_test("misaligned");

        $display("tests ok %0d, tests failed %0d, failed checks %0d",
                 tests_ok, tests_bad, fail_count);
        if (fail_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: src.f
design/fetch_pkg.sv
design/fetch_ctrl_if.sv
design/fetch_control.sv
design/fetch_addr_stage.sv
design/fetch_pair_stage.sv
design/fetch_unit.sv
tb/fetch_mem_model.sv
tb/tb_fetch_unit.sv

// File: Bender.yml
package:
  name: fetch_unit

sources:
  - design/fetch_pkg.sv
  - design/fetch_ctrl_if.sv
  - design/fetch_control.sv
  - design/fetch_addr_stage.sv
  - design/fetch_pair_stage.sv
  - design/fetch_unit.sv
  - target: test
    files:
      - tb/fetch_mem_model.sv
      - tb/tb_fetch_unit.sv
